// ==== verilog/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

  // Word address, one 32-bit word per address
  typedef logic [29:0] lsq_addr_t;

  typedef logic [31:0] lsq_data_t;

  // Operation presented at dispatch
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } lsq_op_t;

  // Memory port FSM
  typedef enum logic [1:0] {
    WB_IDLE  = 2'd0,
    WB_READ  = 2'd1,
    WB_WRITE = 2'd2
  } wb_state_t;

  // Ring slots per queue, power of two
  localparam int LSQ_DEPTH_DEFAULT = 8;

endpackage

`default_nettype wire

// ==== verilog/lsq_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// Load to store queue search, resolved within one cycle
interface fwd_if import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH_DEFAULT
) ();
  logic                     req_valid;
  lsq_addr_t                req_addr;
  logic [$clog2(DEPTH)-1:0] req_bound;
  logic [$clog2(DEPTH)-1:0] sq_tail;
  logic                     hit;
  logic                     blocked;
  lsq_data_t                data;

  modport server (input req_valid, req_addr, req_bound,
                  output sq_tail, hit, blocked, data);
  modport client (output req_valid, req_addr, req_bound,
                  input sq_tail, hit, blocked, data);
endinterface

// Single outstanding memory request, held until ack
interface mem_if import lsq_pkg::*; ();
  logic      req;
  logic      we;
  lsq_addr_t addr;
  lsq_data_t wdata;
  logic      ack;
  lsq_data_t rdata;

  modport requester (output req, we, addr, wdata, input ack, rdata);
  modport server (input req, we, addr, wdata, output ack, rdata);
endinterface

`default_nettype wire

// ==== verilog/store_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_queue import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH_DEFAULT
) (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     disp_store,
  input  wire logic                     st_exec_valid,
  input  wire logic [$clog2(DEPTH)-1:0] st_exec_idx,
  input  wire lsq_addr_t                st_exec_addr,
  input  wire lsq_data_t                st_exec_data,
  input  wire logic                     retire_store,
  output logic                          sq_ready,
  output logic [$clog2(DEPTH)-1:0]      disp_sq_idx,
  fwd_if.server                         fwd,
  mem_if.requester                      mem
);

  typedef logic [$clog2(DEPTH)-1:0] idx_t;

  idx_t            head;
  idx_t            tail;
  idx_t            ret_ptr;
  idx_t            sq_count;
  idx_t            fwd_count;
  idx_t            exec_off;
  idx_t            slot;
  logic [DEPTH-1:0] addr_known;
  logic [DEPTH-1:0] retired;
  lsq_addr_t       st_addr [DEPTH];
  lsq_data_t       st_data [DEPTH];

  // One slot stays empty so full and empty differ
  assign sq_count    = tail - head;
  assign sq_ready    = sq_count < idx_t'(DEPTH - 1);
  assign disp_sq_idx = tail;
  assign exec_off    = st_exec_idx - head;

  assign fwd.sq_tail = tail;
  assign fwd_count   = fwd.req_bound - head;

  // Walk from the youngest older store back to head
  always_comb begin
    fwd.hit     = 1'b0;
    fwd.blocked = 1'b0;
    fwd.data    = '0;
    slot        = '0;
    for (int j = 0; j < DEPTH; j++) begin
      slot = fwd.req_bound - idx_t'(j + 1);
      if (fwd.req_valid && idx_t'(j) < fwd_count) begin
        if (!addr_known[slot]) begin
          fwd.blocked = 1'b1;
        end else if (!fwd.hit && st_addr[slot] == fwd.req_addr) begin
          fwd.hit  = 1'b1;
          fwd.data = st_data[slot];
        end
      end
    end
  end

  // Commit the head once it has retired
  assign mem.req   = (head != tail) && retired[head];
  assign mem.we    = 1'b1;
  assign mem.addr  = st_addr[head];
  assign mem.wdata = st_data[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      ret_ptr    <= '0;
      addr_known <= '0;
      retired    <= '0;
    end else begin
      if (disp_store && sq_ready) begin
        addr_known[tail] <= 1'b0;
        retired[tail]    <= 1'b0;
        tail             <= tail + idx_t'(1);
      end
      if (st_exec_valid) begin
        addr_known[st_exec_idx] <= 1'b1;
      end
      if (retire_store) begin
        retired[ret_ptr] <= 1'b1;
        ret_ptr          <= ret_ptr + idx_t'(1);
      end
      if (mem.req && mem.ack) begin
        head <= head + idx_t'(1);
      end
    end
  end

  // Payload of an executed store
  always_ff @(posedge clock) begin
    if (st_exec_valid) begin
      st_addr[st_exec_idx] <= st_exec_addr;
      st_data[st_exec_idx] <= st_exec_data;
    end
  end

  a_exec_in_range: assert property (@(posedge clock) disable iff (reset)
    st_exec_valid |-> exec_off < sq_count);

  a_retire_known: assert property (@(posedge clock) disable iff (reset)
    retire_store |-> ret_ptr != tail && addr_known[ret_ptr]);

endmodule

`default_nettype wire

// ==== verilog/load_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_queue import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH_DEFAULT
) (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     disp_load,
  input  wire logic                     ld_exec_valid,
  input  wire logic [$clog2(DEPTH)-1:0] ld_exec_idx,
  input  wire lsq_addr_t                ld_exec_addr,
  input  wire logic                     retire_load,
  output logic                          lq_ready,
  output logic [$clog2(DEPTH)-1:0]      disp_lq_idx,
  output logic                          ld_exec_ready,
  output logic                          ld_done,
  output logic [$clog2(DEPTH)-1:0]      ld_done_idx,
  output lsq_data_t                     ld_done_data,
  output logic                          ld_done_fwd,
  fwd_if.client                         fwd,
  mem_if.requester                      mem
);

  typedef logic [$clog2(DEPTH)-1:0] idx_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_SEARCH,
    LD_READ,
    LD_DONE
  } ld_state_t;

  idx_t       head;
  idx_t       tail;
  idx_t       lq_count;
  idx_t       sq_bound [DEPTH];
  logic [DEPTH-1:0] finished;
  ld_state_t  state;
  idx_t       ex_idx;
  lsq_addr_t  ex_addr;
  lsq_data_t  res_data;
  logic       res_fwd;

  assign lq_count    = tail - head;
  assign lq_ready    = lq_count < idx_t'(DEPTH - 1);
  assign disp_lq_idx = tail;

  assign ld_exec_ready = state == LD_IDLE;
  assign ld_done       = state == LD_DONE;
  assign ld_done_idx   = ex_idx;
  assign ld_done_data  = res_data;
  assign ld_done_fwd   = res_fwd;

  // Age boundary of the executing load
  assign fwd.req_valid = state == LD_SEARCH;
  assign fwd.req_addr  = ex_addr;
  assign fwd.req_bound = sq_bound[ex_idx];

  assign mem.req   = state == LD_READ;
  assign mem.we    = 1'b0;
  assign mem.addr  = ex_addr;
  assign mem.wdata = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      finished <= '0;
      state    <= LD_IDLE;
    end else begin
      if (disp_load && lq_ready) begin
        finished[tail] <= 1'b0;
        tail           <= tail + idx_t'(1);
      end
      if (retire_load) begin
        head <= head + idx_t'(1);
      end
      case (state)
        LD_IDLE: begin
          if (ld_exec_valid) begin
            state <= LD_SEARCH;
          end
        end
        LD_SEARCH: begin
          if (fwd.hit && !fwd.blocked) begin
            finished[ex_idx] <= 1'b1;
            state            <= LD_DONE;
          end else if (!fwd.blocked) begin
            state <= LD_READ;
          end
        end
        LD_READ: begin
          if (mem.ack) begin
            finished[ex_idx] <= 1'b1;
            state            <= LD_DONE;
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (disp_load && lq_ready) begin
      sq_bound[tail] <= fwd.sq_tail;
    end
    if (state == LD_IDLE && ld_exec_valid) begin
      ex_idx  <= ld_exec_idx;
      ex_addr <= ld_exec_addr;
    end
    if (state == LD_SEARCH && fwd.hit && !fwd.blocked) begin
      res_data <= fwd.data;
      res_fwd  <= 1'b1;
    end else if (state == LD_READ && mem.ack) begin
      res_data <= mem.rdata;
      res_fwd  <= 1'b0;
    end
  end

  a_retire_done: assert property (@(posedge clock) disable iff (reset)
    retire_load |-> head != tail && finished[head]);

endmodule

`default_nettype wire

// ==== verilog/wb_mem_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_mem_master import lsq_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      wb_ack,
  input  wire lsq_data_t wb_rdata,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output lsq_addr_t      wb_adr,
  output lsq_data_t      wb_wdata,
  mem_if.server          rd,
  mem_if.server          wr
);

  wb_state_t state;

  assign wb_cyc = state != WB_IDLE;
  assign wb_stb = state != WB_IDLE;

  // Ack goes back only to the port being served
  assign rd.ack   = (state == WB_READ) && wb_ack;
  assign wr.ack   = (state == WB_WRITE) && wb_ack;
  assign rd.rdata = wb_rdata;
  assign wr.rdata = wb_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE: begin
          // Loads go first
          if (rd.req) begin
            state <= WB_READ;
          end else if (wr.req) begin
            state <= WB_WRITE;
          end
        end
        default: begin
          if (wb_ack) begin
            state <= WB_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == WB_IDLE) begin
      if (rd.req) begin
        wb_we    <= rd.we;
        wb_adr   <= rd.addr;
        wb_wdata <= rd.wdata;
      end else if (wr.req) begin
        wb_we    <= wr.we;
        wb_adr   <= wr.addr;
        wb_wdata <= wr.wdata;
      end
    end
  end

  // Served requester keeps its request and fields until ack
  a_rd_held: assert property (@(posedge clock) disable iff (reset)
    state == WB_READ |-> rd.req && rd.addr == wb_adr);

  a_wr_held: assert property (@(posedge clock) disable iff (reset)
    state == WB_WRITE |-> wr.req && wr.addr == wb_adr && wr.wdata == wb_wdata);

endmodule

`default_nettype wire

// ==== verilog/lsq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsq_top import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH_DEFAULT
) (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire lsq_op_t                  disp_op,
  output logic                          sq_ready,
  output logic                          lq_ready,
  output logic [$clog2(DEPTH)-1:0]      disp_sq_idx,
  output logic [$clog2(DEPTH)-1:0]      disp_lq_idx,
  input  wire logic                     st_exec_valid,
  input  wire logic [$clog2(DEPTH)-1:0] st_exec_idx,
  input  wire lsq_addr_t                st_exec_addr,
  input  wire lsq_data_t                st_exec_data,
  input  wire logic                     ld_exec_valid,
  input  wire logic [$clog2(DEPTH)-1:0] ld_exec_idx,
  input  wire lsq_addr_t                ld_exec_addr,
  output logic                          ld_exec_ready,
  input  wire logic                     retire_store,
  input  wire logic                     retire_load,
  output logic                          ld_done,
  output logic [$clog2(DEPTH)-1:0]      ld_done_idx,
  output lsq_data_t                     ld_done_data,
  output logic                          ld_done_fwd,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output lsq_addr_t                     wb_adr,
  output lsq_data_t                     wb_wdata,
  input  wire logic                     wb_ack,
  input  wire lsq_data_t                wb_rdata
);

  logic disp_store;
  logic disp_load;

  fwd_if #(.DEPTH(DEPTH)) fwd_bus ();
  mem_if                  st_mem ();
  mem_if                  ld_mem ();

  assign disp_store = disp_op == OP_STORE;
  assign disp_load  = disp_op == OP_LOAD;

  store_queue #(.DEPTH(DEPTH)) store_queue_inst (
    .clock         (clock),
    .reset         (reset),
    .disp_store    (disp_store),
    .st_exec_valid (st_exec_valid),
    .st_exec_idx   (st_exec_idx),
    .st_exec_addr  (st_exec_addr),
    .st_exec_data  (st_exec_data),
    .retire_store  (retire_store),
    .sq_ready      (sq_ready),
    .disp_sq_idx   (disp_sq_idx),
    .fwd           (fwd_bus),
    .mem           (st_mem)
  );

  load_queue #(.DEPTH(DEPTH)) load_queue_inst (
    .clock         (clock),
    .reset         (reset),
    .disp_load     (disp_load),
    .ld_exec_valid (ld_exec_valid),
    .ld_exec_idx   (ld_exec_idx),
    .ld_exec_addr  (ld_exec_addr),
    .retire_load   (retire_load),
    .lq_ready      (lq_ready),
    .disp_lq_idx   (disp_lq_idx),
    .ld_exec_ready (ld_exec_ready),
    .ld_done       (ld_done),
    .ld_done_idx   (ld_done_idx),
    .ld_done_data  (ld_done_data),
    .ld_done_fwd   (ld_done_fwd),
    .fwd           (fwd_bus),
    .mem           (ld_mem)
  );

  wb_mem_master wb_mem_master_inst (
    .clock    (clock),
    .reset    (reset),
    .wb_ack   (wb_ack),
    .wb_rdata (wb_rdata),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .rd       (ld_mem),
    .wr       (st_mem)
  );

endmodule

`default_nettype wire

// ==== verif/lsq_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

  localparam int DEPTH = LSQ_DEPTH_DEFAULT;
  localparam int MAX_WORDS = 4 * 64;

  typedef logic [$clog2(DEPTH)-1:0] idx_t;

  logic clock;
  logic reset;
  lsq_op_t disp_op;
  logic sq_ready, lq_ready, ld_exec_ready, ld_done, ld_done_fwd;
  idx_t disp_sq_idx, disp_lq_idx, st_exec_idx, ld_exec_idx, ld_done_idx;
  logic st_exec_valid, ld_exec_valid, retire_store, retire_load;
  lsq_addr_t st_exec_addr, ld_exec_addr, wb_adr;
  lsq_data_t st_exec_data, ld_done_data, wb_wdata, wb_rdata;
  logic wb_cyc, wb_stb, wb_we, wb_ack;

  logic [31:0] stim [MAX_WORDS];
  int n_lines;
  int fail_count;
  int other_count;
  int seed;
  int ack_wait;
  int lq_unretired;
  int sq_unretired;
  idx_t sq_alloc;
  idx_t lq_alloc;
  lsq_data_t mem_words [lsq_addr_t];
  lsq_addr_t exp_wr_addr [$];
  lsq_data_t exp_wr_data [$];

  // Store whose address arrives later, and a load executed later
  logic st_deferred;
  idx_t def_st_idx, def_ld_idx;
  lsq_addr_t def_st_addr, def_ld_addr;
  lsq_data_t def_st_data;

  lsq_top #(.DEPTH(DEPTH)) lsq_top_inst (.*);

  always #2 clock = ~clock;

  task automatic verify_load_data(input lsq_data_t got, input lsq_data_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t load data %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_fwd_flag(input logic got, input logic exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t forward flag %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic index_equals(input idx_t got, input idx_t exp, input string name);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t %s %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic match_write(input lsq_addr_t got_a, input lsq_data_t got_d,
                             input lsq_addr_t exp_a, input lsq_data_t exp_d);
    if (got_a !== exp_a || got_d !== exp_d) begin
      fail_count++;
      $display("[FAIL] %0t write %h=%h, expected %h=%h", $time, got_a, got_d, exp_a, exp_d);
    end
  endtask

  task automatic ready_is(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic lsq_data_t mem_read(input lsq_addr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return 32'h5a5a0000 + 32'(a);
  endfunction

  // Wishbone slave with 0 to 3 wait states
  always @(posedge clock) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      ack_wait <= 0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait == 0) begin
        wb_ack   <= 1'b1;
        wb_rdata <= mem_read(wb_adr);
        ack_wait <= $random(seed) & 3;
        if (wb_we) begin
          mem_words[wb_adr] = wb_wdata;
          if (exp_wr_addr.size() == 0) begin
            other_count++;
            $display("Unexpected write to %h at %0t", wb_adr, $time);
          end else begin
            match_write(wb_adr, wb_wdata, exp_wr_addr.pop_front(), exp_wr_data.pop_front());
          end
        end
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  // Wishbone classic keeps cyc and stb together
  always @(negedge clock) begin
    if (!reset && wb_stb !== wb_cyc) begin
      other_count++;
      $display("wb_stb and wb_cyc differ at %0t", $time);
    end
  end

  task automatic dispatch(input lsq_op_t op, output idx_t idx);
    @(negedge clock);
    while (!(op == OP_STORE ? sq_ready : lq_ready)) @(negedge clock);
    if (op == OP_STORE) begin
      index_equals(disp_sq_idx, sq_alloc, "disp_sq_idx");
      idx = sq_alloc;
      sq_alloc++;
      sq_unretired++;
    end else begin
      index_equals(disp_lq_idx, lq_alloc, "disp_lq_idx");
      idx = lq_alloc;
      lq_alloc++;
    end
    @(posedge clock);
    disp_op <= op;
    @(posedge clock);
    disp_op <= OP_NONE;
  endtask

  task automatic exec_store(input idx_t idx, input lsq_addr_t a, input lsq_data_t d);
    @(posedge clock);
    st_exec_valid <= 1'b1;
    st_exec_idx   <= idx;
    st_exec_addr  <= a;
    st_exec_data  <= d;
    @(posedge clock);
    st_exec_valid <= 1'b0;
  endtask

  task automatic add_store(input lsq_addr_t a, input lsq_data_t d, input logic later);
    idx_t idx;
    dispatch(OP_STORE, idx);
    exp_wr_addr.push_back(a);
    exp_wr_data.push_back(d);
    if (later) begin
      st_deferred = 1'b1;
      def_st_idx  = idx;
      def_st_addr = a;
      def_st_data = d;
    end else begin
      exec_store(idx, a, d);
    end
  endtask

  task automatic run_load(input idx_t idx, input lsq_addr_t a, input logic exp_fwd,
                          input lsq_data_t exp_data);
    int waited;
    @(negedge clock);
    while (!ld_exec_ready) @(negedge clock);
    @(posedge clock);
    ld_exec_valid <= 1'b1;
    ld_exec_idx   <= idx;
    ld_exec_addr  <= a;
    @(posedge clock);
    ld_exec_valid <= 1'b0;
    // Older store address still unknown, so the load has to wait
    if (st_deferred) begin
      repeat (10) begin
        @(negedge clock);
        if (ld_done) begin
          other_count++;
          $display("Load %0d finished before an older store address was known", idx);
        end
      end
      exec_store(def_st_idx, def_st_addr, def_st_data);
      st_deferred = 1'b0;
    end
    waited = 0;
    @(negedge clock);
    while (!ld_done && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    if (!ld_done) begin
      other_count++;
      $display("Load %0d never completed", idx);
    end else begin
      index_equals(ld_done_idx, idx, "ld_done_idx");
      verify_load_data(ld_done_data, exp_data);
      compare_fwd_flag(ld_done_fwd, exp_fwd);
    end
    lq_unretired++;
  endtask

  task automatic pulse_retires(input int loads, input int stores);
    for (int i = 0; i < loads; i++) begin
      @(posedge clock);
      retire_load <= 1'b1;
      @(posedge clock);
      retire_load <= 1'b0;
    end
    for (int i = 0; i < stores; i++) begin
      @(posedge clock);
      retire_store <= 1'b1;
      @(posedge clock);
      retire_store <= 1'b0;
    end
    lq_unretired -= loads;
    sq_unretired -= stores;
  endtask

  task automatic drain();
    int waited;
    if (st_deferred) begin
      exec_store(def_st_idx, def_st_addr, def_st_data);
      st_deferred = 1'b0;
    end
    pulse_retires(lq_unretired, sq_unretired);
    waited = 0;
    @(negedge clock);
    while ((exp_wr_addr.size() != 0 || wb_cyc) && waited < 500) begin
      @(negedge clock);
      waited++;
    end
    if (exp_wr_addr.size() != 0) begin
      other_count++;
      $display("%0d retired stores were never written", exp_wr_addr.size());
    end
  endtask

  // Fill both rings with retires withheld, then free one slot each
  task automatic fill_queues();
    idx_t st_idx [DEPTH];
    idx_t ld_idx [DEPTH];
    int waited;
    drain();
    for (int i = 0; i < DEPTH - 1; i++) begin
      @(negedge clock);
      ready_is(sq_ready, 1'b1, "sq_ready");
      add_store(30'h200 + 30'(i), 32'hc0de0000 + i, 1'b1);
      st_deferred = 1'b0;
      st_idx[i] = def_st_idx;
    end
    @(negedge clock);
    ready_is(sq_ready, 1'b0, "sq_ready");
    for (int i = 0; i < DEPTH - 1; i++) begin
      exec_store(st_idx[i], 30'h200 + 30'(i), 32'hc0de0000 + i);
    end
    pulse_retires(0, 1);
    waited = 0;
    @(negedge clock);
    while (!sq_ready && waited < 50) begin
      @(negedge clock);
      waited++;
    end
    ready_is(sq_ready, 1'b1, "sq_ready");
    for (int i = 0; i < DEPTH - 1; i++) begin
      @(negedge clock);
      ready_is(lq_ready, 1'b1, "lq_ready");
      dispatch(OP_LOAD, ld_idx[i]);
    end
    @(negedge clock);
    ready_is(lq_ready, 1'b0, "lq_ready");
    for (int i = 0; i < DEPTH - 1; i++) begin
      run_load(ld_idx[i], 30'h100 + 30'(i), 1'b0, 32'h5a5a0100 + i);
    end
    pulse_retires(1, 0);
    @(negedge clock);
    ready_is(lq_ready, 1'b1, "lq_ready");
  endtask

  initial begin
    int kind;
    idx_t idx;
    $readmemh("verif/lsq_stim.txt", stim);
    n_lines = 0;
    while (n_lines < MAX_WORDS / 4 && stim[4 * n_lines] != 0) n_lines++;
    seed = 32'hf059410a;
    fail_count = 0;
    other_count = 0;
    lq_unretired = 0;
    sq_unretired = 0;
    sq_alloc = '0;
    lq_alloc = '0;
    st_deferred = 1'b0;
    clock = 1'b0;
    reset <= 1'b1;
    disp_op <= OP_NONE;
    st_exec_valid <= 1'b0;
    st_exec_idx <= '0;
    st_exec_addr <= '0;
    st_exec_data <= '0;
    ld_exec_valid <= 1'b0;
    ld_exec_idx <= '0;
    ld_exec_addr <= '0;
    retire_store <= 1'b0;
    retire_load <= 1'b0;
    wb_ack <= 1'b0;
    wb_rdata <= '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    ready_is(sq_ready, 1'b1, "sq_ready");
    ready_is(lq_ready, 1'b1, "lq_ready");
    ready_is(ld_exec_ready, 1'b1, "ld_exec_ready");
    ready_is(wb_cyc, 1'b0, "wb_cyc");
    ready_is(wb_stb, 1'b0, "wb_stb");
    ready_is(ld_done, 1'b0, "ld_done");
    for (int i = 0; i < n_lines; i++) begin
      kind = stim[4 * i];
      case (kind)
        1: begin
          dispatch(OP_LOAD, idx);
          run_load(idx, stim[4 * i + 1][29:0], stim[4 * i + 2][0], stim[4 * i + 3]);
        end
        2: add_store(stim[4 * i + 1][29:0], stim[4 * i + 2], 1'b0);
        3: add_store(stim[4 * i + 1][29:0], stim[4 * i + 2], 1'b1);
        4: begin
          dispatch(OP_LOAD, def_ld_idx);
          def_ld_addr = stim[4 * i + 1][29:0];
        end
        5: run_load(def_ld_idx, def_ld_addr, stim[4 * i + 2][0], stim[4 * i + 3]);
        6: drain();
        7: fill_queues();
        default: begin
          other_count++;
          $display("Unknown stimulus kind %0d on line %0d", kind, i);
        end
      endcase
    end
    drain();
    $display("Wrong values: %0d, other failures: %0d", fail_count, other_count);
    if (fail_count == 0 && other_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    #1;
    repeat (200 * (n_lines + 1)) @(posedge clock);
    $display("Watchdog expired, simulation did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/lsq_stim.txt ====
// kind addr data expected; kind 1 load, 2 store, 3 store with late address,
// 4 load dispatched only, 5 run that load, 6 retire all, 7 fill queues; data = fwd flag for loads
1 00000010 00000000 5a5a0010
2 00000010 11111111 00000000
1 00000010 00000001 11111111
2 00000020 22222222 00000000
2 00000010 33333333 00000000
// youngest older store wins
1 00000010 00000001 33333333
1 00000020 00000001 22222222
6 00000000 00000000 00000000
// committed stores come back from memory
1 00000010 00000000 33333333
1 00000020 00000000 22222222
// late store address, load waits then forwards
3 00000030 44444444 00000000
1 00000030 00000001 44444444
// late store address, load waits then reads memory
3 00000040 55555555 00000000
1 00000050 00000000 5a5a0050
// younger store is not seen by the older load
4 00000060 00000000 00000000
2 00000060 66666666 00000000
5 00000060 00000000 5a5a0060
1 00000060 00000001 66666666
6 00000000 00000000 00000000
1 00000060 00000000 66666666
1 00000030 00000000 44444444
1 00000040 00000000 55555555
// full queues and recovery
7 00000000 00000000 00000000
6 00000000 00000000 00000000
1 00000200 00000000 c0de0000
1 00000206 00000000 c0de0006
6 00000000 00000000 00000000
0 00000000 00000000 00000000

// ==== tb.f ====
verilog/lsq_pkg.sv
verilog/lsq_ifs.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/wb_mem_master.sv
verilog/lsq_top.sv
verif/lsq_tb.sv

// ==== Makefile ====
TOP = lsq_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lsq_top -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o lsq_sim
	./obj_dir/lsq_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
